// ==== common/fetch_pkg.sv ====
// Fetch package: data widths, buffer capacity, read limits and AXI constants
package fetch_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Fetch buffer capacity, counted in halfwords
    localparam int BUF_HALFWORDS = 4;
    localparam int BUF_BITS      = BUF_HALFWORDS * 16;   // Buffer storage width

    // Halfword counts, 0 to BUF_HALFWORDS
    localparam int DEPTH_W = $clog2(BUF_HALFWORDS + 1);

    // Largest number of AXI reads in flight
    localparam int MAX_OUTSTANDING = 2;
    localparam int OUT_W           = $clog2(MAX_OUTSTANDING + 1);

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // AXI protection bits for an unprivileged, secure instruction access
    localparam logic [2:0] ARPROT_INSTR = 3'b100;

endpackage

// ==== fetch/fetch_request.sv ====
// Fetch requester: AXI4-Lite read address issue, in-flight tracking, stale response drain
`timescale 1ns/1ps

module fetch_request
    import fetch_pkg::*;
(
    input  logic               g_clk,
    input  logic               reset,
    input  logic               flush,               // Redirect pulse
    input  logic [XLEN-1:0]    redirect_pc,

    output logic [XLEN-1:0]    araddr,
    output logic [2:0]         arprot,
    output logic               arvalid,
    input  logic               arready,

    input  logic [XLEN-1:0]    rdata,
    input  logic [1:0]         rresp,
    input  logic               rvalid,
    output logic               rready,

    output logic               f_4byte,             // Full word into the buffer
    output logic               f_2byte,             // Upper halfword only
    output logic               f_err,
    output logic [XLEN-1:0]    f_in,
    input  logic               f_ready,
    input  logic               space_ok,            // Buffer has room for one more word
    output logic [DEPTH_W-1:0] inflight_halfwords   // Halfwords still to arrive
);

    logic             active;       // Set by the first redirect
    logic             half_first;   // Next live response loads its upper half only
    logic [OUT_W-1:0] outstanding;  // All reads issued and not yet answered
    logic [OUT_W-1:0] discard;      // Reads left over from an old stream
    logic [OUT_W-1:0] out_left;     // Outstanding after this cycle's response
    logic [OUT_W-1:0] live_reads;
    logic [XLEN-1:0]  fetch_addr;   // Next word address to request
    logic [XLEN-1:0]  issue_addr;
    logic             ar_fire;
    logic             r_fire;
    logic             drop;
    logic             ar_free;
    logic             issue;

    assign ar_fire = arvalid && arready;
    assign drop    = discard != '0;                  // Response belongs to an old stream
    assign rready  = drop || (active && f_ready);    // Stale data always drains
    assign r_fire  = rvalid && rready;

    assign out_left = outstanding - OUT_W'(r_fire);
    assign ar_free  = !arvalid || ar_fire;           // AR slot free by next edge

    // A redirect requests its own aligned word straight away
    assign issue_addr = flush ? {redirect_pc[XLEN-1:2], 2'b00} : fetch_addr;
    assign issue      = ar_free && (out_left < MAX_OUTSTANDING) &&
                        (flush || (active && space_ok));

    // Every live read is booked as two halfwords, so the space check is conservative
    assign live_reads         = outstanding - discard;
    assign inflight_halfwords = {live_reads, 1'b0};

    assign arprot  = ARPROT_INSTR;
    assign f_in    = rdata;                          // Data goes straight through
    assign f_err   = rresp != RESP_OKAY;
    assign f_4byte = r_fire && !drop && !half_first;
    assign f_2byte = r_fire && !drop && half_first;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            active      <= 1'b0;
            arvalid     <= 1'b0;
            outstanding <= '0;
            discard     <= '0;
            half_first  <= 1'b0;
        end else begin
            outstanding <= out_left + OUT_W'(issue);
            if (issue) begin
                arvalid <= 1'b1;
            end else if (ar_fire) begin
                arvalid <= 1'b0;
            end
            if (flush) begin
                // Everything still on the bus is now stale
                active     <= 1'b1;
                discard    <= out_left;
                half_first <= redirect_pc[1];
            end else begin
                if (r_fire && drop) begin
                    discard <= discard - 1'b1;
                end
                if (r_fire && !drop) begin
                    half_first <= 1'b0;      // Only the first word is split
                end
            end
        end
    end

    // Address registers, stable while arvalid waits for arready
    always_ff @(posedge g_clk) begin
        if (issue) begin
            araddr     <= issue_addr;
            fetch_addr <= issue_addr + XLEN'(4);
        end else if (flush) begin
            fetch_addr <= issue_addr;        // AR busy, new stream starts after it
        end
    end

endmodule

// ==== fetch/fetch_buffer.sv ====
// Fetch buffer: halfword shift store that splits words into 16-bit and 32-bit instructions
`timescale 1ns/1ps

module fetch_buffer
    import fetch_pkg::*;
(
    input  logic               g_clk,
    input  logic               reset,
    input  logic               flush,

    input  logic               f_4byte,             // Two halfwords in
    input  logic               f_2byte,             // One halfword in, from f_in[31:16]
    input  logic               f_err,
    input  logic [XLEN-1:0]    f_in,
    output logic               f_ready,             // Room for a full word this cycle

    input  logic [DEPTH_W-1:0] inflight_halfwords,
    output logic               space_ok,            // Room for one more request

    output logic               buf_valid,
    output logic               buf_16,              // Oldest instruction is compressed
    output logic [XLEN-1:0]    buf_out,
    output logic               buf_err,
    input  logic               buf_ready
);

    logic [BUF_BITS-1:0]      buffer;               // Oldest halfword in the low bits
    logic [BUF_HALFWORDS-1:0] buffer_err;           // One error bit per halfword
    logic [DEPTH_W-1:0]       depth;

    logic                     eat_2;
    logic                     eat_4;
    logic [DEPTH_W-1:0]       add_hw;
    logic [DEPTH_W-1:0]       sub_hw;
    logic [DEPTH_W-1:0]       insert_at;
    logic [DEPTH_W:0]         committed;
    logic [XLEN-1:0]          ins_data;
    logic [1:0]               ins_err;
    logic [BUF_BITS-1:0]      n_buffer;
    logic [BUF_HALFWORDS-1:0] n_buffer_err;

    // Instruction length comes from the low bits of the oldest halfword
    assign buf_out   = buffer[XLEN-1:0];
    assign buf_16    = buf_out[1:0] != 2'b11;
    assign buf_valid = buf_16 ? (depth >= DEPTH_W'(1)) : (depth >= DEPTH_W'(2));
    assign buf_err   = buf_16 ? buffer_err[0] : |buffer_err[1:0];

    assign eat_2 = buf_valid && buf_ready && buf_16;
    assign eat_4 = buf_valid && buf_ready && !buf_16;

    assign add_hw    = {1'b0, f_4byte, f_2byte};
    assign sub_hw    = {1'b0, eat_4, eat_2};
    assign insert_at = depth - sub_hw;               // First free slot after removal

    // Word fits once this cycle's instruction has left
    assign f_ready = insert_at <= DEPTH_W'(BUF_HALFWORDS - 2);

    // Stored plus expected halfwords must leave room for another word
    assign committed = depth + inflight_halfwords + (DEPTH_W + 1)'(2);
    assign space_ok  = committed <= (DEPTH_W + 1)'(BUF_HALFWORDS);

    // Incoming data, zero when nothing arrives
    always_comb begin
        ins_data = '0;
        ins_err  = 2'b00;
        if (f_4byte) begin
            ins_data = f_in;
            ins_err  = {2{f_err}};
        end else if (f_2byte) begin
            ins_data = {16'b0, f_in[XLEN-1:16]};
            ins_err  = {1'b0, f_err};
        end
    end

    // Shift out the consumed halfwords, then lay the new ones behind the rest
    assign n_buffer = (buffer >> {sub_hw, 4'b0000}) |
                      ({{(BUF_BITS - XLEN){1'b0}}, ins_data} << {insert_at, 4'b0000});
    assign n_buffer_err = (buffer_err >> sub_hw) |
                          ({{(BUF_HALFWORDS - 2){1'b0}}, ins_err} << insert_at);

    // Empty slots must read as zero for the OR merge above
    always_ff @(posedge g_clk) begin
        if (reset || flush) begin
            buffer     <= '0;
            buffer_err <= '0;
            depth      <= '0;
        end else begin
            buffer     <= n_buffer;
            buffer_err <= n_buffer_err;
            depth      <= depth + add_hw - sub_hw;
        end
    end

endmodule

// ==== source/instr_predecode.sv ====
// Predecode stage: running PC and the instruction output register
`timescale 1ns/1ps

module instr_predecode
    import fetch_pkg::*;
(
    input  logic            g_clk,
    input  logic            reset,
    input  logic            flush,
    input  logic [XLEN-1:0] redirect_pc,        // Loaded as the running PC on flush

    input  logic            buf_valid,
    input  logic            buf_16,
    input  logic [XLEN-1:0] buf_out,
    input  logic            buf_err,
    output logic            buf_ready,

    output logic            out_valid,
    input  logic            out_ready,
    output logic [XLEN-1:0] out_pc,
    output logic [XLEN-1:0] out_instr,
    output logic            out_compressed,
    output logic            out_err
);

    logic [XLEN-1:0] pc;        // PC of the next instruction from the buffer
    logic            buf_fire;

    // Register takes a new entry when empty or when its entry leaves
    assign buf_ready = !out_valid || out_ready;
    assign buf_fire  = buf_valid && buf_ready;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            pc        <= '0;
        end else if (flush) begin
            out_valid <= 1'b0;                      // Old stream dropped
            pc        <= redirect_pc;
        end else begin
            if (buf_fire) begin
                out_valid <= 1'b1;
                pc        <= pc + (buf_16 ? XLEN'(2) : XLEN'(4));
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Payload, held while out_ready is low
    always_ff @(posedge g_clk) begin
        if (buf_fire) begin
            out_pc         <= pc;
            out_compressed <= buf_16;
            out_err        <= buf_err;
            // Compressed form keeps only its own halfword
            out_instr      <= buf_16 ? {16'b0, buf_out[15:0]} : buf_out;
        end
    end

endmodule

// ==== source/fetch_top.sv ====
// Fetch front end top: requester, halfword buffer and predecode stage
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic            g_clk,
    input  logic            reset,

    // Redirect, one-cycle pulse
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,

    // AXI4-Lite read address
    output logic [XLEN-1:0] araddr,
    output logic [2:0]      arprot,
    output logic            arvalid,
    input  logic            arready,

    // AXI4-Lite read data
    input  logic [XLEN-1:0] rdata,
    input  logic [1:0]      rresp,
    input  logic            rvalid,
    output logic            rready,

    // Instruction output
    output logic            out_valid,
    input  logic            out_ready,
    output logic [XLEN-1:0] out_pc,
    output logic [XLEN-1:0] out_instr,
    output logic            out_compressed,
    output logic            out_err
);

    logic               flush;
    logic               f_4byte;
    logic               f_2byte;
    logic               f_err;
    logic [XLEN-1:0]    f_in;
    logic               f_ready;
    logic               space_ok;
    logic [DEPTH_W-1:0] inflight_halfwords;
    logic               buf_valid;
    logic               buf_16;
    logic [XLEN-1:0]    buf_out;
    logic               buf_err;
    logic               buf_ready;

    assign flush = redirect;    // Whole pipe restarts on a redirect

    fetch_request u_fetch_request (
        .g_clk              (g_clk),
        .reset              (reset),
        .flush              (flush),
        .redirect_pc        (redirect_pc),
        .araddr             (araddr),
        .arprot             (arprot),
        .arvalid            (arvalid),
        .arready            (arready),
        .rdata              (rdata),
        .rresp              (rresp),
        .rvalid             (rvalid),
        .rready             (rready),
        .f_4byte            (f_4byte),
        .f_2byte            (f_2byte),
        .f_err              (f_err),
        .f_in               (f_in),
        .f_ready            (f_ready),
        .space_ok           (space_ok),
        .inflight_halfwords (inflight_halfwords)
    );

    fetch_buffer u_fetch_buffer (
        .g_clk              (g_clk),
        .reset              (reset),
        .flush              (flush),
        .f_4byte            (f_4byte),
        .f_2byte            (f_2byte),
        .f_err              (f_err),
        .f_in               (f_in),
        .f_ready            (f_ready),
        .inflight_halfwords (inflight_halfwords),
        .space_ok           (space_ok),
        .buf_valid          (buf_valid),
        .buf_16             (buf_16),
        .buf_out            (buf_out),
        .buf_err            (buf_err),
        .buf_ready          (buf_ready)
    );

    instr_predecode u_instr_predecode (
        .g_clk          (g_clk),
        .reset          (reset),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .buf_valid      (buf_valid),
        .buf_16         (buf_16),
        .buf_out        (buf_out),
        .buf_err        (buf_err),
        .buf_ready      (buf_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_pc         (out_pc),
        .out_instr      (out_instr),
        .out_compressed (out_compressed),
        .out_err        (out_err)
    );

endmodule

// ==== tb/tb_imem_model.sv ====
// AXI4-Lite read-only instruction memory with random response latency and one error word
`timescale 1ns/1ps

module tb_imem_model
    import fetch_pkg::*;
#(
    parameter int WORDS    = 64,
    parameter int ERR_WORD = 20         // Word that answers with SLVERR
) (
    input  logic            g_clk,
    input  logic            reset,
    input  logic [XLEN-1:0] araddr,
    input  logic            arvalid,
    output logic            arready,
    output logic [XLEN-1:0] rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  logic            rready
);

    logic [XLEN-1:0] mem [WORDS];
    logic [XLEN-1:0] pending [$];       // Accepted read addresses, oldest first
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] fill;
    int              seed;
    int              wait_cnt;          // Cycles before the next response
    int              idx;

    assign arready = 1'b1;              // Addresses always queue up

    initial begin
        seed     = 95054;
        wait_cnt = 0;
        rvalid   = 1'b0;
        rdata    = '0;
        rresp    = RESP_OKAY;
        for (int i = 0; i < WORDS; i++) begin
            fill = $random(seed);
            // Bit 2 of each halfword picks 32-bit, else a 16-bit quadrant
            fill[1:0]   = fill[2] ? 2'b11 : {1'b0, fill[0]};
            fill[17:16] = fill[18] ? 2'b11 : {1'b0, fill[16]};
            mem[i] = fill;
        end
        mem[8][17:16] = 2'b11;                  // 32-bit op across words 8 and 9
        mem[ERR_WORD-1][1:0]   = 2'b01;         // 16-bit op just before the error word
        mem[ERR_WORD-1][17:16] = 2'b11;         // 32-bit op running into it
    end

    always @(posedge g_clk) begin
        if (reset) begin
            rvalid   <= 1'b0;
            wait_cnt = 0;
            pending.delete();
        end else begin
            if (arvalid && arready) begin
                pending.push_back(araddr);
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            // Next response once the data channel frees up
            if ((!rvalid || rready) && pending.size() > 0) begin
                if (wait_cnt == 0) begin
                    addr = pending.pop_front();
                    idx  = int'((addr >> 2) % WORDS);   // Addresses wrap over the array
                    rvalid <= 1'b1;
                    rdata  <= mem[idx];
                    rresp  <= (idx == ERR_WORD) ? RESP_SLVERR : RESP_OKAY;
                    wait_cnt = $random(seed) & 3;       // 0 to 3 idle cycles
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

// ==== tb/tb_fetch_top.sv ====
// Fetch front end testbench: stimulus table, reference instruction walk, checks and timeout
`timescale 1ns/1ps

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int NUM_TESTS = 6;
    localparam int WORDS     = 64;
    localparam int ERR_WORD  = 20;      // Byte address 0x50

    typedef struct packed {
        logic [31:0] pc;                // First redirect target
        int          count;             // Instructions checked after the last redirect
        int          stall;             // Percent of cycles with out_ready low
        int          cyc2;              // Cycle of a second redirect, 0 for none
        logic [31:0] pc2;
    } test_row_t;

    test_row_t       tests [NUM_TESTS];
    logic            g_clk;
    logic            reset;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] araddr;
    logic [2:0]      arprot;
    logic            arvalid;
    logic            arready;
    logic [XLEN-1:0] rdata;
    logic [1:0]      rresp;
    logic            rvalid;
    logic            rready;
    logic            out_valid;
    logic            out_ready;
    logic [XLEN-1:0] out_pc;
    logic [XLEN-1:0] out_instr;
    logic            out_compressed;
    logic            out_err;
    int              seed;
    int              cycle_limit;
    int              cycle_count = 0;

    fetch_top u_fetch_top (.*);

    tb_imem_model #(.WORDS(WORDS), .ERR_WORD(ERR_WORD)) u_imem (.*);

    initial g_clk = 1'b0;
    always #5 g_clk = ~g_clk;           // 10 ns period

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the fetch output stalled, run stopped after %0d cycles",
                     cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Run did not complete in time");
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    function automatic logic [15:0] halfword_at(input logic [31:0] addr);
        logic [31:0] word;
        word = u_imem.mem[int'((addr >> 2) % WORDS)];
        return addr[1] ? word[31:16] : word[15:0];
    endfunction

    function automatic logic in_err_word(input logic [31:0] addr);
        return ((addr >> 2) % WORDS) == ERR_WORD;
    endfunction

    // Next instruction of the walk against the current output transfer
    task automatic check_transfer(inout logic [31:0] pc);
        logic [15:0] low;
        logic [31:0] instr;
        logic        comp;
        logic        err;
        low   = halfword_at(pc);
        comp  = low[1:0] != 2'b11;                  // Binary 11 means a 32-bit op
        instr = comp ? {16'b0, low} : {halfword_at(pc + 2), low};
        err   = in_err_word(pc) || (!comp && in_err_word(pc + 2));
        check_value(out_pc, pc, "out_pc");
        check_value(out_instr, instr, "out_instr");
        check_value(32'(out_compressed), 32'(comp), "out_compressed");
        check_value(32'(out_err), 32'(err), "out_err");
        pc = pc + (comp ? 32'd2 : 32'd4);
    endtask

    task automatic load_tests();
        // PC, count, stall %, second redirect cycle, second PC
        tests[0] = '{32'h0000_0000, 12, 0, 0, 32'h0};             // Aligned mixed stream
        tests[1] = '{32'h0000_0022, 10, 0, 0, 32'h0};             // Halfword start
        tests[2] = '{32'h0000_0040, 8, 0, 3, 32'h0000_00a6};      // Reads still in flight
        tests[3] = '{32'h0000_004c, 10, 0, 0, 32'h0};             // Across the error word
        tests[4] = '{32'h0000_0060, 40, 30, 0, 32'h0};
        tests[5] = '{32'h0000_00c2, 20, 25, 9, 32'h0000_0012};    // Stalls plus redirect
    endtask

    task automatic run_test(input int r);
        logic [31:0] walk_pc;
        int          row_cycle;
        int          got;
        int          seen;                  // Redirects of this row seen so far
        int          rnd;
        bit          last_stream;
        bit          done;
        walk_pc   = '0;
        row_cycle = 0;
        got       = 0;
        seen      = 0;
        done      = 0;
        @(posedge g_clk);
        redirect    <= 1'b1;
        redirect_pc <= tests[r].pc;
        while (!done) begin
            @(negedge g_clk);
            last_stream = (tests[r].cyc2 == 0) ? (seen == 1) : (seen == 2);
            // Transfers before this row's redirect belong to the last row
            if (out_valid && out_ready && seen > 0) begin
                check_transfer(walk_pc);
                got = got + int'(last_stream);
            end
            if (arvalid) begin
                // AXI protection: instruction, secure, unprivileged
                check_value(32'(arprot), 32'(3'b100), "arprot");
            end
            if (redirect) begin
                seen++;
                walk_pc = redirect_pc;      // Walk restarts with the new stream
                got     = 0;
            end
            last_stream = (tests[r].cyc2 == 0) ? (seen == 1) : (seen == 2);
            done = last_stream && got == tests[r].count;
            if (!done) begin
                @(posedge g_clk);
                row_cycle++;
                rnd = $random(seed) & 32'h7fff_ffff;
                out_ready <= (rnd % 100) >= tests[r].stall;
                redirect  <= row_cycle == tests[r].cyc2;
                if (row_cycle == tests[r].cyc2) begin
                    redirect_pc <= tests[r].pc2;
                end
            end
        end
    endtask

    initial begin
        seed        = 95054;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        out_ready   = 1'b1;
        load_tests();
        cycle_limit = 200;
        for (int r = 0; r < NUM_TESTS; r++) begin
            cycle_limit = cycle_limit + tests[r].count * 40;
        end
        repeat (3) @(posedge g_clk);
        reset <= 1'b0;
        @(negedge g_clk);
        check_value(32'(arvalid), 32'd0, "arvalid after reset");
        check_value(32'(rready), 32'd0, "rready after reset");
        check_value(32'(out_valid), 32'd0, "out_valid after reset");
        for (int r = 0; r < NUM_TESTS; r++) begin
            run_test(r);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
common/fetch_pkg.sv
fetch/fetch_request.sv
fetch/fetch_buffer.sv
source/instr_predecode.sv
source/fetch_top.sv
tb/tb_imem_model.sv
tb/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the fetch testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_fetch_top -o sim_fetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
